// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic clk,
    input  logic wrValid,
    input  logic [31:0] wrAddr,
    input  logic [31:0] wrData,
    input  logic [3:0] wrWmask,
    input  logic [31:0] rdAddr,
    output logic [31:0] readData
);

    logic [31:0] mem [lsuPkg::MEM_WORDS];

    lsuPkg::MemAddr wrA;
    lsuPkg::MemAddr rdA;
    logic [lsuPkg::MEM_IDX_W-1:0] wrIdx;
    logic [lsuPkg::MEM_IDX_W-1:0] rdIdx;
    logic wrEn;

    assign wrA = wrAddr;
    assign rdA = rdAddr;
    assign wrIdx = wrA.mem.wordIdx[lsuPkg::MEM_IDX_W-1:0];
    assign rdIdx = rdA.mem.wordIdx[lsuPkg::MEM_IDX_W-1:0];

    // IO region belongs to the IO port
    assign wrEn = wrValid && (wrA.io.region != lsuPkg::IO_SELECT);

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (wrWmask[b])
                    mem[wrIdx][8*b +: 8] <= wrData[8*b +: 8];
            end
        end
    end

    // Read returns the old word on a same-edge write
    always_ff @(posedge clk) begin
        readData <= mem[rdIdx];
    end

endmodule

// ==== hdl/ioPort.sv ====
`timescale 1ns/1ps

module ioPort (
    input  logic clk,
    input  logic rst,
    input  logic wrValid,
    input  logic [31:0] wrAddr,
    input  logic [31:0] wrData,
    input  logic [3:0] wrWmask,
    output logic ioBusy,
    output logic [31:0] ioData
);

    lsuPkg::MemAddr wrA;
    logic ioWrite;
    logic [lsuPkg::IO_CNT_W-1:0] busyCnt;

    assign wrA = wrAddr;
    assign ioWrite = wrValid && (wrA.io.region == lsuPkg::IO_SELECT);
    assign ioBusy = busyCnt != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busyCnt <= '0;
            ioData <= '0;
        end else if (ioWrite) begin
            busyCnt <= lsuPkg::IO_CNT_W'(lsuPkg::IO_BUSY_CYCLES);
            for (int b = 0; b < 4; b++) begin
                if (wrWmask[b])
                    ioData[8*b +: 8] <= wrData[8*b +: 8];
            end
        end else if (ioBusy) begin
            busyCnt <= busyCnt - 1'b1;
        end
    end

    noWriteWhileBusy: assert property (@(posedge clk) disable iff (rst)
        ioWrite |-> !ioBusy)
        else $error("IO write arrived while the port was busy");

endmodule

// ==== hdl/loadMerge.sv ====
`timescale 1ns/1ps

module loadMerge (
    input  logic clk,
    input  logic rst,
    input  logic ldPending,
    input  logic [31:0] readData,
    input  logic [31:0] fwdData,
    input  logic [3:0] fwdMask,
    output logic ldResultValid,
    output logic [31:0] ldResultData
);

    logic [31:0] merged;

    // Forwarded store bytes take priority over the RAM word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (fwdMask[b])
                merged[8*b +: 8] = fwdData[8*b +: 8];
            else
                merged[8*b +: 8] = readData[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            ldResultValid <= 1'b0;
        else
            ldResultValid <= ldPending;
    end

    always_ff @(posedge clk) begin
        ldResultData <= merged;
    end

    // Store queue only forwards for a live load
    fwdOnlyForLoad: assert property (@(posedge clk) disable iff (rst)
        !ldPending |-> fwdMask == '0)
        else $error("forwarding mask set with no load pending");

endmodule

// ==== hdl/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic clk,
    input  logic rst,
    input  logic stValid,
    input  logic [lsuPkg::SQN_W-1:0] stSqN,
    input  logic [lsuPkg::SQN_W-1:0] stStoreSqN,
    input  logic [31:0] stAddr,
    input  logic [31:0] stData,
    input  logic [3:0] stWmask,
    input  logic stException,
    input  logic [lsuPkg::SQN_W-1:0] curSqN,
    input  logic brTaken,
    input  logic [lsuPkg::SQN_W-1:0] brSqN,
    input  logic [lsuPkg::SQN_W-1:0] brStoreSqN,
    input  logic brFlush,
    input  logic ldValid,
    input  logic [lsuPkg::SQN_W-1:0] ldSqN,
    input  logic [31:0] ldAddr,
    output logic sqEmpty,
    output logic [lsuPkg::SQN_W-1:0] maxStoreSqN,
    output logic ldResultValid,
    output logic [31:0] ldResultData,
    output logic ioBusy,
    output logic [31:0] ioData
);

    logic wrValid;
    logic [31:0] wrAddr;
    logic [31:0] wrData;
    logic [3:0] wrWmask;
    logic [31:0] fwdData;
    logic [3:0] fwdMask;
    logic [31:0] readData;
    logic ldPending;

    // Lines up with the registered RAM read and forwarding result
    always_ff @(posedge clk) begin
        if (rst)
            ldPending <= 1'b0;
        else
            ldPending <= ldValid;
    end

    storeQueue u_storeQueue (
        .clk(clk), .rst(rst),
        .stValid(stValid), .stSqN(stSqN), .stStoreSqN(stStoreSqN),
        .stAddr(stAddr), .stData(stData), .stWmask(stWmask), .stException(stException),
        .curSqN(curSqN),
        .brTaken(brTaken), .brSqN(brSqN), .brStoreSqN(brStoreSqN), .brFlush(brFlush),
        .ldValid(ldValid), .ldSqN(ldSqN), .ldAddr(ldAddr),
        .ioBusy(ioBusy),
        .wrValid(wrValid), .wrAddr(wrAddr), .wrData(wrData), .wrWmask(wrWmask),
        .fwdData(fwdData), .fwdMask(fwdMask),
        .sqEmpty(sqEmpty), .maxStoreSqN(maxStoreSqN)
    );

    dataMemory u_dataMemory (
        .clk(clk),
        .wrValid(wrValid), .wrAddr(wrAddr), .wrData(wrData), .wrWmask(wrWmask),
        .rdAddr(ldAddr), .readData(readData)
    );

    ioPort u_ioPort (
        .clk(clk), .rst(rst),
        .wrValid(wrValid), .wrAddr(wrAddr), .wrData(wrData), .wrWmask(wrWmask),
        .ioBusy(ioBusy), .ioData(ioData)
    );

    loadMerge u_loadMerge (
        .clk(clk), .rst(rst),
        .ldPending(ldPending), .readData(readData),
        .fwdData(fwdData), .fwdMask(fwdMask),
        .ldResultValid(ldResultValid), .ldResultData(ldResultData)
    );

endmodule

// ==== hdl/lsuPkg.sv ====
package lsuPkg;

    // Sequence number width for sqN and storeSqN
    localparam int SQN_W = 7;

    localparam int SQ_ENTRIES = 8;
    localparam int SQ_IDX_W = $clog2(SQ_ENTRIES);

    // Covers retirement up to the memory write becoming readable
    localparam int RETIRED_DEPTH = 3;

    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Top address byte of the memory-mapped IO region
    localparam logic [7:0] IO_SELECT = 8'hFF;
    localparam int IO_BUSY_CYCLES = 3;
    localparam int IO_CNT_W = $clog2(IO_BUSY_CYCLES + 1);

    // One byte address, seen either as a RAM word or as an IO register
    typedef union packed {
        struct packed {
            logic [29:0] wordIdx;
            logic [1:0] byteOff;
        } mem;
        struct packed {
            logic [7:0] region;
            logic [21:0] ioReg;
            logic [1:0] byteOff;
        } io;
    } MemAddr;

endpackage

// ==== hdl/storeQueue.sv ====
`timescale 1ns/1ps

module storeQueue (
    input  logic clk,
    input  logic rst,
    input  logic stValid,
    input  logic [lsuPkg::SQN_W-1:0] stSqN,
    input  logic [lsuPkg::SQN_W-1:0] stStoreSqN,
    input  logic [31:0] stAddr,
    input  logic [31:0] stData,
    input  logic [3:0] stWmask,
    input  logic stException,
    input  logic [lsuPkg::SQN_W-1:0] curSqN,
    input  logic brTaken,
    input  logic [lsuPkg::SQN_W-1:0] brSqN,
    input  logic [lsuPkg::SQN_W-1:0] brStoreSqN,
    input  logic brFlush,
    input  logic ldValid,
    input  logic [lsuPkg::SQN_W-1:0] ldSqN,
    input  logic [31:0] ldAddr,
    input  logic ioBusy,
    output logic wrValid,
    output logic [31:0] wrAddr,
    output logic [31:0] wrData,
    output logic [3:0] wrWmask,
    output logic [31:0] fwdData,
    output logic [3:0] fwdMask,
    output logic sqEmpty,
    output logic [lsuPkg::SQN_W-1:0] maxStoreSqN
);

    localparam int N = lsuPkg::SQ_ENTRIES;
    localparam int RD = lsuPkg::RETIRED_DEPTH;

    // True when a comes after b in wrapped sequence order
    function automatic logic isLater(input logic [lsuPkg::SQN_W-1:0] a,
                                     input logic [lsuPkg::SQN_W-1:0] b);
        logic [lsuPkg::SQN_W-1:0] diff;
        diff = a - b;
        return !diff[lsuPkg::SQN_W-1] && (diff != '0);
    endfunction

    function automatic logic [31:0] overlay(input logic [31:0] old,
                                            input logic [31:0] data,
                                            input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // Entry 0 is the oldest store
    logic [N-1:0] entValid;
    logic [N-1:0] entReady;
    logic [lsuPkg::SQN_W-1:0] entSqN [N];
    lsuPkg::MemAddr entAddr [N];
    logic [31:0] entData [N];
    logic [3:0] entWmask [N];

    // Retired window, index 0 newest
    logic [RD-1:0] retValid;
    lsuPkg::MemAddr retAddr [RD];
    logic [31:0] retData [RD];
    logic [3:0] retWmask [RD];

    logic [lsuPkg::SQN_W-1:0] baseIdx;
    logic [lsuPkg::SQN_W-1:0] baseNext;
    logic [lsuPkg::SQN_W-1:0] stDist;
    logic [lsuPkg::SQ_IDX_W-1:0] slot;
    logic [N-1:0] readyNow;
    logic stAccept;
    logic doRetire;
    logic headIsIo;
    logic wrIsIo;
    lsuPkg::MemAddr ldA;
    lsuPkg::MemAddr wrA;
    logic [31:0] fwdDataNext;
    logic [3:0] fwdMaskNext;

    assign ldA = ldAddr;
    assign wrA = wrAddr;
    assign wrIsIo = wrA.io.region == lsuPkg::IO_SELECT;
    assign headIsIo = entAddr[0].io.region == lsuPkg::IO_SELECT;

    always_comb begin
        for (int i = 0; i < N; i++)
            readyNow[i] = entReady[i] || isLater(curSqN, entSqN[i]);
    end

    // IO head waits for the port and for the IO write already in flight
    assign doRetire = entValid[0] && entReady[0] && !brTaken &&
                      !(headIsIo && (ioBusy || (wrValid && wrIsIo)));

    assign stAccept = stValid && !stException && (!brTaken || !isLater(stSqN, brSqN));
    assign stDist = stStoreSqN - baseIdx;
    // Slot moves down by one when the queue shifts in the same cycle
    assign slot = stDist[lsuPkg::SQ_IDX_W-1:0] - lsuPkg::SQ_IDX_W'(doRetire);

    always_comb begin
        if (brTaken && brFlush)
            baseNext = brStoreSqN + 1'b1;
        else if (doRetire)
            baseNext = baseIdx + 1'b1;
        else
            baseNext = baseIdx;
    end

    always_comb begin
        fwdMaskNext = '0;
        fwdDataNext = '0;
        if (ldValid) begin
            for (int i = RD - 1; i >= 0; i--) begin
                if (retValid[i] && retAddr[i].mem.wordIdx == ldA.mem.wordIdx) begin
                    fwdDataNext = overlay(fwdDataNext, retData[i], retWmask[i]);
                    fwdMaskNext = fwdMaskNext | retWmask[i];
                end
            end
            for (int i = 0; i < N; i++) begin
                if (entValid[i] && entAddr[i].mem.wordIdx == ldA.mem.wordIdx &&
                    (isLater(ldSqN, entSqN[i]) || entReady[i])) begin
                    fwdDataNext = overlay(fwdDataNext, entData[i], entWmask[i]);
                    fwdMaskNext = fwdMaskNext | entWmask[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            entReady <= '0;
            retValid <= '0;
            baseIdx <= '0;
            wrValid <= 1'b0;
            fwdMask <= '0;
            sqEmpty <= 1'b1;
            maxStoreSqN <= lsuPkg::SQN_W'(N - 1);
        end else begin
            if (doRetire) begin
                for (int i = 0; i < N - 1; i++) begin
                    entValid[i] <= entValid[i+1];
                    entReady[i] <= readyNow[i+1];
                    entSqN[i] <= entSqN[i+1];
                    entAddr[i] <= entAddr[i+1];
                    entData[i] <= entData[i+1];
                    entWmask[i] <= entWmask[i+1];
                end
                entValid[N-1] <= 1'b0;
                entReady[N-1] <= 1'b0;

                retValid <= {retValid[RD-2:0], 1'b1};
                retAddr[0] <= entAddr[0];
                retData[0] <= entData[0];
                retWmask[0] <= entWmask[0];
                for (int i = 1; i < RD; i++) begin
                    retAddr[i] <= retAddr[i-1];
                    retData[i] <= retData[i-1];
                    retWmask[i] <= retWmask[i-1];
                end
            end else begin
                entReady <= readyNow;
                // Mispredict drops uncommitted younger stores
                if (brTaken) begin
                    for (int i = 0; i < N; i++) begin
                        if (isLater(entSqN[i], brSqN) && !entReady[i])
                            entValid[i] <= 1'b0;
                    end
                end
            end

            if (stAccept) begin
                entValid[slot] <= 1'b1;
                entReady[slot] <= 1'b0;
                entSqN[slot] <= stSqN;
                entAddr[slot] <= {stAddr[31:2], 2'b00};
                entData[slot] <= stData;
                entWmask[slot] <= stWmask;
            end

            wrValid <= doRetire;
            baseIdx <= baseNext;
            maxStoreSqN <= baseNext + lsuPkg::SQN_W'(N - 1);
            sqEmpty <= (entValid == '0) && !stAccept;
            fwdMask <= fwdMaskNext;
        end

        wrAddr <= entAddr[0];
        wrData <= entData[0];
        wrWmask <= entWmask[0];
        fwdData <= fwdDataNext;
    end

    enqueueInWindow: assert property (@(posedge clk) disable iff (rst)
        stAccept |-> stDist < lsuPkg::SQN_W'(N))
        else $error("store enqueued outside the queue window");

    ioRetireWhenIdle: assert property (@(posedge clk) disable iff (rst)
        (wrValid && wrIsIo) |-> !ioBusy)
        else $error("IO store retired while the IO port was busy");

endmodule

// ==== project.f ====
hdl/lsuPkg.sv
hdl/storeQueue.sv
hdl/dataMemory.sv
hdl/ioPort.sv
hdl/loadMerge.sv
hdl/loadStoreUnit.sv
tb/loadStoreUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message is printed
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module loadStoreUnitTb \
    && ./obj_dir/VloadStoreUnitTb | tee /dev/stderr | grep -q 'All tests passed!' \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb/loadStoreUnitTb.sv ====
`timescale 1ns/1ps

module loadStoreUnitTb;

    localparam int W = lsuPkg::SQN_W;
    // Directed and random phases take roughly 500 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] IO_ADDR = 32'hFF00_0010;

    logic clk = 1'b0;
    logic rst;
    logic stValid;
    logic [W-1:0] stSqN;
    logic [W-1:0] stStoreSqN;
    logic [31:0] stAddr;
    logic [31:0] stData;
    logic [3:0] stWmask;
    logic stException;
    logic [W-1:0] curSqN;
    logic brTaken;
    logic [W-1:0] brSqN;
    logic [W-1:0] brStoreSqN;
    logic brFlush;
    logic ldValid;
    logic [W-1:0] ldSqN;
    logic [31:0] ldAddr;
    logic sqEmpty;
    logic [W-1:0] maxStoreSqN;
    logic ldResultValid;
    logic [31:0] ldResultData;
    logic ioBusy;
    logic [31:0] ioData;

    // Model store queue, oldest first; the first committedCnt entries are committed
    logic [W-1:0] mqSqN [$];
    logic [31:0] mqAddr [$];
    logic [31:0] mqData [$];
    logic [3:0] mqMask [$];
    int committedCnt = 0;
    logic [31:0] modelMem [256];
    logic [31:0] modelIo = '0;

    logic [31:0] expQ [$];
    string nameQ [$];
    string testName = "reset";
    logic [W-1:0] nextSqN = 1;
    logic [W-1:0] nextStoreSqN = 0;
    logic [31:0] lcgState = 32'h1fdb0b11;
    int cycle = 0;
    int ioGap = 100;
    int busyLeft = 0;
    logic [1:0] ldPipe = '0;
    int errors = 0;
    int loadsChecked = 0;

    loadStoreUnit u_loadStoreUnit (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [W-1:0] takeSqN();
        logic [W-1:0] s;
        s = nextSqN;
        nextSqN = nextSqN + 1'b1;
        return s;
    endfunction

    function automatic logic [31:0] wordAddr(input logic [1:0] k);
        return 32'h40 + {28'd0, k, 2'b00};
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // Memory image, then every committed store and every uncommitted one older than the load
    function automatic logic [31:0] expectedLoad(input logic [31:0] addr,
                                                 input logic [W-1:0] loadSqN);
        logic [31:0] word;
        logic [W-1:0] diff;
        word = modelMem[addr[9:2]];
        for (int i = 0; i < mqAddr.size(); i++) begin
            diff = loadSqN - mqSqN[i];
            if (mqAddr[i][31:2] == addr[31:2] &&
                (i < committedCnt || (!diff[W-1] && diff != '0)))
                word = mergeBytes(word, mqData[i], mqMask[i]);
        end
        return word;
    endfunction

    task automatic nextEdge();
        @(posedge clk);
        stValid <= 1'b0;
        ldValid <= 1'b0;
        brTaken <= 1'b0;
        brFlush <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) nextEdge();
    endtask

    task automatic storeWord(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask, input logic [W-1:0] sqN);
        nextEdge();
        stValid <= 1'b1;
        stSqN <= sqN;
        stStoreSqN <= nextStoreSqN;
        stAddr <= addr;
        stData <= data;
        stWmask <= mask;
        mqSqN.push_back(sqN);
        mqAddr.push_back(addr);
        mqData.push_back(data);
        mqMask.push_back(mask);
        nextStoreSqN = nextStoreSqN + 1'b1;
    endtask

    task automatic loadWord(input logic [31:0] addr, input logic [W-1:0] sqN);
        nextEdge();
        ldValid <= 1'b1;
        ldSqN <= sqN;
        ldAddr <= addr;
        expQ.push_back(expectedLoad(addr, sqN));
        nameQ.push_back(testName);
    endtask

    task automatic commitAll();
        nextEdge();
        curSqN <= nextSqN;
        committedCnt = mqAddr.size();
    endtask

    task automatic flushAfter(input logic [W-1:0] branchSqN, input logic [W-1:0] keepStoreSqN);
        logic [W-1:0] diff;
        nextEdge();
        brTaken <= 1'b1;
        brFlush <= 1'b1;
        brSqN <= branchSqN;
        brStoreSqN <= keepStoreSqN;
        for (int i = mqAddr.size() - 1; i >= committedCnt; i--) begin
            diff = mqSqN[i] - branchSqN;
            if (!diff[W-1] && diff != '0) begin
                mqSqN.delete(i);
                mqAddr.delete(i);
                mqData.delete(i);
                mqMask.delete(i);
            end
        end
        nextStoreSqN = keepStoreSqN + 1'b1;
    endtask

    task automatic waitDrained();
        do
            nextEdge();
        while (mqAddr.size() != 0 || !sqEmpty || ioBusy);
        idle(2);
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Retirement monitor keeps the memory and IO images in step with the DUT
    always @(posedge clk) begin
        ioGap++;
        if (!rst) begin
            assert (ioBusy === (busyLeft > 0))
            else begin
                $display("[FAIL] %s ioBusy expected %b actual %b",
                         testName, busyLeft > 0, ioBusy);
                errors++;
            end
        end
        if (busyLeft > 0)
            busyLeft--;
        if (!rst && u_loadStoreUnit.wrValid) begin
            if (committedCnt == 0) begin
                $display("A store retired before it was committed");
                errors++;
            end else begin
                assert (u_loadStoreUnit.wrAddr[31:2] == mqAddr[0][31:2])
                else begin
                    $display("[FAIL] %s retire address expected %h actual %h",
                             testName, mqAddr[0], u_loadStoreUnit.wrAddr);
                    errors++;
                end
                assert (u_loadStoreUnit.wrData == mqData[0])
                else begin
                    $display("[FAIL] %s retire data expected %h actual %h",
                             testName, mqData[0], u_loadStoreUnit.wrData);
                    errors++;
                end
                if (mqAddr[0][31:24] == lsuPkg::IO_SELECT) begin
                    assert (ioGap >= lsuPkg::IO_BUSY_CYCLES)
                    else begin
                        $display("[FAIL] %s IO gap expected >= %0d actual %0d",
                                 testName, lsuPkg::IO_BUSY_CYCLES, ioGap);
                        errors++;
                    end
                    ioGap = 0;
                    busyLeft = lsuPkg::IO_BUSY_CYCLES;
                    modelIo = mergeBytes(modelIo, mqData[0], mqMask[0]);
                end else begin
                    modelMem[mqAddr[0][9:2]] = mergeBytes(modelMem[mqAddr[0][9:2]],
                                                          mqData[0], mqMask[0]);
                end
                void'(mqSqN.pop_front());
                void'(mqAddr.pop_front());
                void'(mqData.pop_front());
                void'(mqMask.pop_front());
                committedCnt--;
            end
        end
    end

    always @(posedge clk) begin
        logic [31:0] want;
        string name;
        // A load seen by the DUT at one edge returns valid two edges later
        if (!rst) begin
            assert (ldResultValid === ldPipe[1])
            else begin
                $display("[FAIL] %s ldResultValid expected %b actual %b",
                         testName, ldPipe[1], ldResultValid);
                errors++;
            end
        end
        ldPipe = {ldPipe[0], ldValid};
        if (!rst && ldResultValid) begin
            if (expQ.size() == 0) begin
                $display("A load result arrived with no load outstanding");
                errors++;
            end else begin
                want = expQ.pop_front();
                name = nameQ.pop_front();
                assert (ldResultData === want)
                else begin
                    $display("[FAIL] %s expected %h actual %h", name, want, ldResultData);
                    errors++;
                end
                loadsChecked++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [W-1:0] branchSq;
        logic [W-1:0] keepSq;
        logic [W-1:0] loadSq;
        rst = 1'b1;
        stValid = 1'b0;
        stSqN = '0;
        stStoreSqN = '0;
        stAddr = '0;
        stData = '0;
        stWmask = '0;
        stException = 1'b0;
        curSqN = '0;
        brTaken = 1'b0;
        brSqN = '0;
        brStoreSqN = '0;
        brFlush = 1'b0;
        ldValid = 1'b0;
        ldSqN = '0;
        ldAddr = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        idle(2);
        assert (sqEmpty === 1'b1)
        else begin
            $display("[FAIL] reset sqEmpty expected 1 actual %b", sqEmpty);
            errors++;
        end
        assert (maxStoreSqN === W'(lsuPkg::SQ_ENTRIES - 1))
        else begin
            $display("[FAIL] reset maxStoreSqN expected %0d actual %0d",
                     lsuPkg::SQ_ENTRIES - 1, maxStoreSqN);
            errors++;
        end

        testName = "preload";
        for (int k = 0; k < 4; k++)
            storeWord(wordAddr(2'(k)), nextRandom(), 4'hF, takeSqN());
        commitAll();
        waitDrained();

        testName = "commit and retire";
        storeWord(wordAddr(2'd0), nextRandom(), 4'b0101, takeSqN());
        commitAll();
        waitDrained();
        loadWord(wordAddr(2'd0), takeSqN());

        testName = "older store forwarding";
        storeWord(wordAddr(2'd1), nextRandom(), 4'b0011, takeSqN());
        storeWord(wordAddr(2'd1), nextRandom(), 4'b0110, takeSqN());
        loadWord(wordAddr(2'd1), takeSqN());
        commitAll();
        waitDrained();

        testName = "younger store hidden";
        loadSq = takeSqN();
        storeWord(wordAddr(2'd2), nextRandom(), 4'hF, takeSqN());
        loadWord(wordAddr(2'd2), loadSq);
        commitAll();
        loadWord(wordAddr(2'd2), takeSqN());
        waitDrained();

        testName = "branch flush";
        branchSq = takeSqN();
        // Flush restarts store numbering away from the current base
        keepSq = nextStoreSqN + W'(3);
        storeWord(wordAddr(2'd3), nextRandom(), 4'hF, takeSqN());
        storeWord(wordAddr(2'd3), nextRandom(), 4'b1100, takeSqN());
        loadWord(wordAddr(2'd3), takeSqN());
        flushAfter(branchSq, keepSq);
        loadWord(wordAddr(2'd3), takeSqN());
        idle(2);
        assert (maxStoreSqN === keepSq + W'(lsuPkg::SQ_ENTRIES))
        else begin
            $display("[FAIL] %s maxStoreSqN expected %0d actual %0d", testName,
                     keepSq + W'(lsuPkg::SQ_ENTRIES), maxStoreSqN);
            errors++;
        end
        waitDrained();

        testName = "IO stores";
        for (int k = 0; k < 3; k++)
            storeWord(IO_ADDR, nextRandom(), 4'(nextRandom()), takeSqN());
        commitAll();
        waitDrained();
        assert (ioData === modelIo)
        else begin
            $display("[FAIL] %s expected %h actual %h", testName, modelIo, ioData);
            errors++;
        end

        testName = "random mix";
        repeat (80) begin
            r = nextRandom();
            if (mqAddr.size() >= 6 || W'(nextSqN - curSqN) > W'(40) || r[2:0] == 3'd0)
                commitAll();
            else if (r[2:0] < 3'd4)
                storeWord(wordAddr(r[9:8]), nextRandom(), r[7:4], takeSqN());
            else
                loadWord(wordAddr(r[9:8]), takeSqN());
        end
        commitAll();
        waitDrained();
        idle(2);

        assert (expQ.size() == 0)
        else begin
            $display("Some loads never returned a result");
            errors++;
        end
        $display("Loads checked: %0d, errors: %0d", loadsChecked, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
